// File: Bender.yml
package:
  name: dmr_lockstep

sources:
  - common/dmr_pkg.sv
  - design/dmr_regs.sv
  - design/dmr_compare.sv
  - dmr_ctrl/dmr_ctrl.sv
  - design/dmr_recovery.sv
  - design/dmr_top.sv
  - target: simulation
    files:
      - tb/tb_dmr_top.sv

// File: common/dmr_pkg.sv
// DMR lockstep supervisor shared widths, register map, types and mode encoding
`default_nettype none

package dmr_pkg;

  // Register port
  localparam int unsigned RegAddrWidth = 4;
  localparam int unsigned RegDataWidth = 32;

  // Core observation and error statistics
  localparam int unsigned CoreDataWidth    = 32;
  localparam int unsigned MismatchCntWidth = 8;

  // Restore window length and the counter width needed to hold it
  localparam int unsigned RecoveryCycles   = 8;
  localparam int unsigned RecoveryCntWidth = $clog2(RecoveryCycles + 1);

  typedef logic [RegAddrWidth-1:0]     reg_addr_t;
  typedef logic [RegDataWidth-1:0]     reg_data_t;
  typedef logic [CoreDataWidth-1:0]    core_word_t;
  typedef logic [MismatchCntWidth-1:0] mismatch_cnt_t;
  typedef logic [RecoveryCntWidth-1:0] recovery_cnt_t;

  // Word addresses of the software registers
  localparam reg_addr_t RegAddrEnable = reg_addr_t'(0);
  localparam reg_addr_t RegAddrConfig = reg_addr_t'(1);
  localparam reg_addr_t RegAddrCount  = reg_addr_t'(2);

  // Bit positions inside the config register
  localparam int unsigned CfgRapidBit = 0;
  localparam int unsigned CfgForceBit = 1;

  // Counter saturates here
  localparam mismatch_cnt_t MismatchCntMax = '1;

  // Observable outputs of one core
  typedef struct packed {
    core_word_t pc;
    core_word_t wdata;
    logic       we;
  } core_out_t;

  // Register values as seen by the hardware
  typedef struct packed {
    logic dmr_enable;
    logic rapid_recovery;
    logic force_recovery;
  } dmr_cfg_t;

  typedef enum logic [1:0] {
    NON_DMR,
    DMR_RUN,
    DMR_RESTORE
  } dmr_mode_e;

endpackage

`default_nettype wire

// File: design/dmr_compare.sv
// DMR compare stage that samples both core bundles and flags any difference
`timescale 1ns/1ps
`default_nettype none

module dmr_compare (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire dmr_pkg::core_out_t core_a_i,
  input  wire dmr_pkg::core_out_t core_b_i,
  input  wire logic               dmr_active_i,
  output logic                    mismatch_o
);

  dmr_pkg::core_out_t core_a_q, core_b_q;
  logic               mismatch_q;
  logic               differ;

  // Sampled core outputs
  always_ff @(posedge clk_i) begin
    core_a_q <= core_a_i;
    core_b_q <= core_b_i;
  end

  // Pc, write data and write enable all take part in the compare
  assign differ = (core_a_q != core_b_q);

  // Only meaningful while the pair runs in lockstep
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mismatch_q <= 1'b0;
    end else begin
      mismatch_q <= dmr_active_i && differ;
    end
  end

  assign mismatch_o = mismatch_q;

endmodule

`default_nettype wire

// File: design/dmr_recovery.sv
// DMR recovery stage that times the fixed-length restore window
`timescale 1ns/1ps
`default_nettype none

module dmr_recovery (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic recovery_req_i,
  output logic      recovery_done_o,
  output logic      recovery_active_o
);

  dmr_pkg::recovery_cnt_t cnt_q, cnt_cur;
  logic                   req_q;
  logic                   start;

  assign start = recovery_req_i & ~req_q;

  // The first cycle of the request already counts as part of the window
  assign cnt_cur = start ? dmr_pkg::recovery_cnt_t'(dmr_pkg::RecoveryCycles) : cnt_q;

  assign recovery_active_o = recovery_req_i && (cnt_cur != '0);
  assign recovery_done_o   = recovery_req_i && (cnt_cur == dmr_pkg::recovery_cnt_t'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
      cnt_q <= '0;
    end else begin
      req_q <= recovery_req_i;
      if (recovery_active_o) begin
        cnt_q <= dmr_pkg::recovery_cnt_t'(cnt_cur - 1'b1);
      end else begin
        // Dropped request aborts the window
        cnt_q <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/dmr_regs.sv
// DMR software registers for enable, config, force-recovery and mismatch count
`timescale 1ns/1ps
`default_nettype none

module dmr_regs (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               reg_we_i,
  input  wire dmr_pkg::reg_addr_t reg_addr_i,
  input  wire dmr_pkg::reg_data_t reg_wdata_i,
  output dmr_pkg::reg_data_t      reg_rdata_o,
  output dmr_pkg::dmr_cfg_t       cfg_o,
  input  wire logic               force_clear_i,
  input  wire logic               incr_mismatch_i
);

  dmr_pkg::dmr_cfg_t      cfg_q;
  dmr_pkg::mismatch_cnt_t cnt_q;

  logic wr_enable, wr_config, wr_count;

  assign wr_enable = reg_we_i && (reg_addr_i == dmr_pkg::RegAddrEnable);
  assign wr_config = reg_we_i && (reg_addr_i == dmr_pkg::RegAddrConfig);
  assign wr_count  = reg_we_i && (reg_addr_i == dmr_pkg::RegAddrCount);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '0;
      cnt_q <= '0;
    end else begin
      if (wr_enable) begin
        cfg_q.dmr_enable <= reg_wdata_i[0];
      end
      if (wr_config) begin
        cfg_q.rapid_recovery <= reg_wdata_i[dmr_pkg::CfgRapidBit];
        cfg_q.force_recovery <= reg_wdata_i[dmr_pkg::CfgForceBit];
      end
      // Hardware clear takes priority over a software write
      if (force_clear_i) begin
        cfg_q.force_recovery <= 1'b0;
      end
      if (wr_count) begin
        cnt_q <= '0;
      end else if (incr_mismatch_i && (cnt_q != dmr_pkg::MismatchCntMax)) begin
        cnt_q <= dmr_pkg::mismatch_cnt_t'(cnt_q + 1'b1);
      end
    end
  end

  // Combinational read-back
  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      dmr_pkg::RegAddrEnable: reg_rdata_o[0] = cfg_q.dmr_enable;
      dmr_pkg::RegAddrConfig: begin
        reg_rdata_o[dmr_pkg::CfgRapidBit] = cfg_q.rapid_recovery;
        reg_rdata_o[dmr_pkg::CfgForceBit] = cfg_q.force_recovery;
      end
      dmr_pkg::RegAddrCount:  reg_rdata_o = dmr_pkg::reg_data_t'(cnt_q);
      default:                reg_rdata_o = '0;
    endcase
  end

  assign cfg_o = cfg_q;

endmodule

`default_nettype wire

// File: design/dmr_top.sv
// DMR lockstep supervisor top chaining compare, control, recovery and registers
`timescale 1ns/1ps
`default_nettype none

module dmr_top (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               reg_we_i,
  input  wire dmr_pkg::reg_addr_t reg_addr_i,
  input  wire dmr_pkg::reg_data_t reg_wdata_i,
  output dmr_pkg::reg_data_t      reg_rdata_o,
  input  wire dmr_pkg::core_out_t core_a_i,
  input  wire dmr_pkg::core_out_t core_b_i,
  input  wire logic               fetch_en_i,
  input  wire logic               cores_synch_i,
  output logic [1:0]              setback_o,
  output logic                    sw_synch_req_o,
  output logic                    sw_resynch_req_o,
  output logic                    grp_in_independent_o,
  output logic                    recovery_active_o
);

  dmr_pkg::dmr_cfg_t cfg;
  logic              force_clear;
  logic              mismatch;
  logic              incr_mismatch;
  logic              recovery_req;
  logic              recovery_done;
  logic              dmr_active;

  assign dmr_active = ~grp_in_independent_o;

  dmr_compare compare_i (
    .clk_i,
    .rst_ni,
    .core_a_i,
    .core_b_i,
    .dmr_active_i (dmr_active),
    .mismatch_o   (mismatch)
  );

  dmr_ctrl ctrl_i (
    .clk_i,
    .rst_ni,
    .cfg_i           (cfg),
    .force_clear_o   (force_clear),
    .mismatch_i      (mismatch),
    .fetch_en_i,
    .cores_synch_i,
    .setback_o,
    .sw_synch_req_o,
    .sw_resynch_req_o,
    .grp_in_independent_o,
    .incr_mismatch_o (incr_mismatch),
    .recovery_req_o  (recovery_req),
    .recovery_done_i (recovery_done)
  );

  dmr_recovery recovery_i (
    .clk_i,
    .rst_ni,
    .recovery_req_i  (recovery_req),
    .recovery_done_o (recovery_done),
    .recovery_active_o
  );

  dmr_regs regs_i (
    .clk_i,
    .rst_ni,
    .reg_we_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .cfg_o           (cfg),
    .force_clear_i   (force_clear),
    .incr_mismatch_i (incr_mismatch)
  );

endmodule

`default_nettype wire

// File: dmr_ctrl/dmr_ctrl.sv
// DMR control stage running the redundancy-mode FSM and the synch requests
`timescale 1ns/1ps
`default_nettype none

module dmr_ctrl (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire dmr_pkg::dmr_cfg_t cfg_i,
  output logic                   force_clear_o,
  input  wire logic              mismatch_i,
  input  wire logic              fetch_en_i,
  input  wire logic              cores_synch_i,
  output logic [1:0]             setback_o,
  output logic                   sw_synch_req_o,
  output logic                   sw_resynch_req_o,
  output logic                   grp_in_independent_o,
  output logic                   incr_mismatch_o,
  output logic                   recovery_req_o,
  input  wire logic              recovery_done_i
);

  dmr_pkg::dmr_mode_e mode_d, mode_q;

  logic synch_req, synch_req_q;
  logic resynch_req, resynch_req_q;
  logic cores_synch_q;

  assign grp_in_independent_o = (mode_q == dmr_pkg::NON_DMR);
  assign recovery_req_o       = (mode_q == dmr_pkg::DMR_RESTORE);

  // Requests are sent once per rising edge of the condition
  assign sw_synch_req_o   = synch_req & ~synch_req_q;
  assign sw_resynch_req_o = resynch_req & ~resynch_req_q;

  always_comb begin
    mode_d          = mode_q;
    setback_o       = 2'b00;
    force_clear_o   = 1'b0;
    incr_mismatch_o = 1'b0;
    synch_req       = 1'b0;
    resynch_req     = 1'b0;

    case (mode_q)
      dmr_pkg::DMR_RUN: begin
        if (cfg_i.force_recovery && cfg_i.rapid_recovery) begin
          force_clear_o = 1'b1;
          mode_d        = dmr_pkg::DMR_RESTORE;
        end
        if (mismatch_i) begin
          incr_mismatch_o = 1'b1;
          if (cfg_i.rapid_recovery) begin
            mode_d = dmr_pkg::DMR_RESTORE;
          end else begin
            resynch_req = 1'b1;
          end
        end
      end
      dmr_pkg::DMR_RESTORE: begin
        if (recovery_done_i) begin
          mode_d = dmr_pkg::DMR_RUN;
        end
      end
      default: begin
        // Independent mode waits until both cores report they are aligned
        if (cfg_i.dmr_enable) begin
          synch_req = 1'b1;
          if (cores_synch_q) begin
            if (cfg_i.rapid_recovery) begin
              mode_d = dmr_pkg::DMR_RESTORE;
            end else begin
              mode_d    = dmr_pkg::DMR_RUN;
              setback_o = 2'b11;
            end
          end
        end
      end
    endcase

    // Before the cores fetch, the enable alone picks the mode
    if (!fetch_en_i) begin
      if (cfg_i.dmr_enable) begin
        synch_req = 1'b0;
        mode_d    = dmr_pkg::DMR_RUN;
      end else begin
        mode_d = dmr_pkg::NON_DMR;
      end
    end

    // Leaving lockstep is allowed at any time
    if ((mode_q == dmr_pkg::DMR_RUN) && !cfg_i.dmr_enable) begin
      mode_d    = dmr_pkg::NON_DMR;
      setback_o = 2'b10;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q        <= dmr_pkg::NON_DMR;
      synch_req_q   <= 1'b0;
      resynch_req_q <= 1'b0;
      cores_synch_q <= 1'b0;
    end else begin
      mode_q        <= mode_d;
      synch_req_q   <= synch_req;
      resynch_req_q <= resynch_req;
      cores_synch_q <= cores_synch_i;
    end
  end

endmodule

`default_nettype wire

// File: flist.f
common/dmr_pkg.sv
design/dmr_regs.sv
design/dmr_compare.sv
dmr_ctrl/dmr_ctrl.sv
design/dmr_recovery.sv
design/dmr_top.sv
tb/tb_dmr_top.sv

// File: tb/tb_dmr_top.sv
// Testbench for the DMR lockstep supervisor, applying a table of register, core and synch cases
`timescale 1ns/1ps
`default_nettype none

module tb_dmr_top;

  localparam int NumRows     = 9;
  localparam int Rc          = dmr_pkg::RecoveryCycles;
  localparam int CoreOutBits = $bits(dmr_pkg::core_out_t);

  // One test case with its stimulus and the expected responses
  typedef struct packed {
    logic       wr_cfg;
    logic [1:0] cfg_val;
    logic       wr_en;
    logic       en_val;
    logic       clr_cnt;
    logic       fetch_en;
    logic       cores_synch;
    int         n_mismatch;
    logic       exp_indep;
    int         exp_synch;
    int         exp_resynch;
    int         exp_sb10;
    int         exp_sb11;
    int         exp_rec;
    logic       exp_en;
    logic [1:0] exp_cfg;
    int         exp_cnt;
  } row_t;

  // Stimulus columns wcfg cfg wen en clr fetch synch mism
  // Expected columns indep synch resynch sb10 sb11 rec en cfg cnt
  row_t rows [NumRows] = '{
    '{1'b0, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 0,
      1'b1, 0, 0, 0, 0, 0, 1'b0, 2'd0, 0},
    '{1'b1, 2'd0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1,
      1'b0, 0, 1, 0, 0, 0, 1'b1, 2'd0, 1},
    '{1'b1, 2'd1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1,
      1'b0, 0, 0, 0, 0, Rc, 1'b1, 2'd1, 2},
    '{1'b1, 2'd3, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 0,
      1'b0, 0, 0, 0, 0, Rc, 1'b1, 2'd1, 2},
    '{1'b1, 2'd0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 0,
      1'b1, 0, 0, 1, 0, 0, 1'b0, 2'd0, 2},
    '{1'b0, 2'd0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 0,
      1'b1, 1, 0, 0, 0, 0, 1'b1, 2'd0, 2},
    '{1'b0, 2'd0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 0,
      1'b0, 0, 0, 0, 1, 0, 1'b1, 2'd0, 2},
    '{1'b0, 2'd0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 260,
      1'b0, 0, 260, 0, 0, 0, 1'b1, 2'd0, 255},
    '{1'b0, 2'd0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 0,
      1'b0, 0, 0, 0, 0, 0, 1'b1, 2'd0, 0}
  };

  logic               clk_i = 1'b0;
  logic               rst_ni = 1'b0;
  logic               reg_we_i = 1'b0;
  dmr_pkg::reg_addr_t reg_addr_i = '0;
  dmr_pkg::reg_data_t reg_wdata_i = '0;
  dmr_pkg::reg_data_t reg_rdata_o;
  dmr_pkg::core_out_t core_a_i = '0;
  dmr_pkg::core_out_t core_b_i = '0;
  logic               fetch_en_i = 1'b0;
  logic               cores_synch_i = 1'b0;
  logic [1:0]         setback_o;
  logic               sw_synch_req_o, sw_resynch_req_o;
  logic               grp_in_independent_o, recovery_active_o;

  int seed = 32'h2790553c;
  int n_errors = 0;
  int n_pass = 0;
  int n_fail = 0;
  // Running event totals that each test compares against its start values
  int n_synch = 0;
  int n_resynch = 0;
  int n_sb10 = 0;
  int n_sb11 = 0;
  int n_rec = 0;

  dmr_top dut_i (.*);

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    if (sw_synch_req_o) n_synch <= n_synch + 1;
    if (sw_resynch_req_o) n_resynch <= n_resynch + 1;
    if (setback_o == 2'b10) n_sb10 <= n_sb10 + 1;
    if (setback_o == 2'b11) n_sb11 <= n_sb11 + 1;
    if (recovery_active_o) n_rec <= n_rec + 1;
  end

  task automatic check_value(input int got, input int exp, input string what);
    assert (got == exp) else begin
      $display("FAIL at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      n_errors++;
    end
  endtask

  task automatic write_reg(input dmr_pkg::reg_addr_t addr, input dmr_pkg::reg_data_t data);
    @(negedge clk_i);
    reg_we_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
  endtask

  task automatic read_reg(input dmr_pkg::reg_addr_t addr, output dmr_pkg::reg_data_t data);
    @(negedge clk_i);
    reg_we_i   = 1'b0;
    reg_addr_i = addr;
    @(posedge clk_i);
    data = reg_rdata_o;
  endtask

  // Random data on core A and a copy on core B with one bit flipped on request
  task automatic drive_cores(input logic flip);
    dmr_pkg::core_out_t     word;
    logic [31:0]            rnd;
    logic [CoreOutBits-1:0] mask;
    int                     bit_idx;
    @(negedge clk_i);
    word.pc    = $random(seed);
    word.wdata = $random(seed);
    rnd        = $random(seed);
    word.we    = rnd[0];
    mask       = '0;
    if (flip) begin
      bit_idx       = int'($unsigned($random(seed)) % CoreOutBits);
      mask[bit_idx] = 1'b1;
    end
    core_a_i = word;
    core_b_i = dmr_pkg::core_out_t'(word ^ mask);
  endtask

  task automatic apply_row(input row_t r, input int idx);
    int                 b_synch, b_resynch, b_sb10, b_sb11, b_rec;
    int                 errs_before;
    dmr_pkg::reg_data_t rd;
    errs_before = n_errors;
    @(negedge clk_i);
    fetch_en_i    = r.fetch_en;
    cores_synch_i = r.cores_synch;
    b_synch       = n_synch;
    b_resynch     = n_resynch;
    b_sb10        = n_sb10;
    b_sb11        = n_sb11;
    b_rec         = n_rec;
    if (r.wr_cfg) write_reg(dmr_pkg::RegAddrConfig, dmr_pkg::reg_data_t'(r.cfg_val));
    if (r.wr_en) write_reg(dmr_pkg::RegAddrEnable, dmr_pkg::reg_data_t'(r.en_val));
    if (r.clr_cnt) write_reg(dmr_pkg::RegAddrCount, '0);
    @(negedge clk_i);
    reg_we_i = 1'b0;
    repeat (3) @(negedge clk_i);
    // Separate the mismatches so each one gives its own pulse
    for (int m = 0; m < r.n_mismatch; m++) begin
      drive_cores(1'b1);
      drive_cores(1'b0);
    end
    repeat (16) @(negedge clk_i);
    check_value(n_synch - b_synch, r.exp_synch, "sw_synch_req_o pulses");
    check_value(n_resynch - b_resynch, r.exp_resynch, "sw_resynch_req_o pulses");
    check_value(n_sb10 - b_sb10, r.exp_sb10, "setback 10 cycles");
    check_value(n_sb11 - b_sb11, r.exp_sb11, "setback 11 cycles");
    check_value(n_rec - b_rec, r.exp_rec, "recovery_active_o cycles");
    check_value(int'(grp_in_independent_o), int'(r.exp_indep), "grp_in_independent_o");
    read_reg(dmr_pkg::RegAddrEnable, rd);
    check_value(int'(rd), int'(r.exp_en), "enable register");
    read_reg(dmr_pkg::RegAddrConfig, rd);
    check_value(int'(rd), int'(r.exp_cfg), "config register");
    read_reg(dmr_pkg::RegAddrCount, rd);
    check_value(int'(rd), r.exp_cnt, "mismatch count register");
    if (n_errors == errs_before) begin
      n_pass++;
      $display("test %0d ok", idx);
    end else begin
      n_fail++;
      $display("test %0d failed with %0d errors", idx, n_errors - errs_before);
    end
  endtask

  initial begin
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    for (int i = 0; i < NumRows; i++) begin
      apply_row(rows[i], i);
    end
    $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Budget of 40 cycles per test plus two per injected mismatch
  initial begin
    longint budget;
    budget = 10;
    for (int i = 0; i < NumRows; i++) begin
      budget += 40 + 2 * rows[i].n_mismatch;
    end
    #(budget * 100);
    $display("Timeout: the tests did not finish within %0d clock cycles", budget);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire
